// File: verification/trig_tests.txt
# op T name | W addr data strobe | I frontA trigAll | D idle cycles
# op R addr expected word | K addr expected difference from the previous read
T config_readback
W 108 12345678 f
R 108 12345678
W 108 aabbccdd 2
R 108 1234cc78
W 108 aabbccdd 9
R 108 aa34ccdd
W 11b deadbeef c
R 11b dead0000
R 055 00000000
T status_block
W 000 00000001 1
W 003 00000001 1
R 001 b1000001
R 000 00000001
R 0ff 00000000
W 003 00000002 1
R 001 00000123
W 003 00000003 3
R 000 00000123
W 003 00000000 1
R 000 00000001
T coincidence
W 108 0000ff0f f
W 118 00003405 f
W 10b ffff0000 f
W 11b 12340000 f
W 120 000000ff 1
W 123 000000ff 1
W 003 00000001 1
I 34f5 1234abcd
R 005 00000003
I 34f4 1234abcd
R 005 00000002
I 34f5 1235abcd
R 005 00000001
I 0000 00000000
R 005 00000000
T multiplicity
W 110 0000f0f0 f
W 113 ffffffff f
W 120 00000005 1
W 123 00000010 1
I 3cff 0000ff0f
D 4
R 110 00000006
R 113 0000000c
R 005 00000100
I 0010 ffffff7f
D 4
R 110 00000001
R 113 0000001f
R 005 00000200
I 10f0 00ff00ff
D 4
R 110 00000005
R 113 00000010
R 005 00000300
T trig_count
I 0000 00000000
W 009 00000001 1
D 4
R 00a 00000000
I 0000 00000080
D 4
I 0000 00000000
D 4
I 0000 00000080
D 4
I 0000 00000000
D 4
I 0000 00000080
D 4
I 0000 00000000
D 4
R 00a 00000003
R 00b 00000000
W 009 00000000 1
D 4
R 00a 00000000
T run_ticks
W 009 00000000 1
D 1
R 00c 00000000
D 9
K 00c 0000000a
D 20
K 00c 00000015
R 00d 00000000

// File: flist.f
+incdir+common
common/trigLogicPkg.sv
design/regBank.sv
design/groupMatch.sv
design/runCounters.sv
design/trigTop.sv
verification/trigTop_tb.sv

// File: Bender.yml
package:
  name: trig_logic

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/trigLogicPkg.sv
      - design/regBank.sv
      - design/groupMatch.sv
      - design/runCounters.sv
      - design/trigTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/trigTop_tb.sv

// File: verification/trigTop_tb.sv
`timescale 1ns/1ps
`include "trigLogic_defines.svh"

module trigTop_tb
   import trigLogicPkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_SKEW = 5;
   localparam int RESET_CYCLES = 5;
   localparam int CYCLES_PER_LINE = 20;

   logic reset;
   logic proc_clk;
   regBusT bus;
   frontLanesT frontA;
   backLanesT trigAll;
   logic [31:0] rdData;

   // line count of the test data sizes the watchdog
   int lineCount;
   string testName;
   // last word read feeds the counter step checks
   logic [31:0] lastRead;

   trigTop uut (
      .reset    (reset),
      .proc_clk (proc_clk),
      .bus      (bus),
      .frontA   (frontA),
      .trigAll  (trigAll),
      .rdData   (rdData)
   );

   // 100 ns period
   always #(CLK_PERIOD / 2) proc_clk = ~proc_clk;

   // ************************************************************************
   // bus helpers
   // ************************************************************************

   // advance one cycle and land just after the edge
   task automatic nextCycle();
      @(posedge proc_clk);
      #DRIVE_SKEW;
   endtask

   // one strobed write lands on the next edge
   task automatic writeWord(input logic [`TRIG_ADDR_BITS-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      bus.addr = addr;
      bus.wrData = data;
      bus.wrStrb = strb;
      nextCycle();
      bus.wrStrb = '0;
   endtask

   // rdData is registered and valid one cycle after rdEn
   task automatic readWord(input logic [`TRIG_ADDR_BITS-1:0] addr, output logic [31:0] value);
      bus.addr = addr;
      bus.rdEn = 1'b1;
      nextCycle();
      bus.rdEn = 1'b0;
      value = rdData;
   endtask

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("error: test %s, %s expected %h actual %h", testName, what, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // bad or short line in the data file
   task automatic badLine(input string op);
      $display("test %s: malformed line in test data at command %s", testName, op);
      $display("*** TEST FAILED ***");
      $fatal(1, "malformed test data");
   endtask

   // ************************************************************************
   // watchdog
   // ************************************************************************
   initial
   begin
      wait (lineCount > 0);
      #(lineCount * CYCLES_PER_LINE * CLK_PERIOD);
      $display("timeout: the test data did not finish in %0d cycles",
               lineCount * CYCLES_PER_LINE);
      $display("*** TEST FAILED ***");
      $fatal(1, "watchdog expired");
   end

   // ************************************************************************
   // main sequence, driven from the data file
   // ************************************************************************
   initial
   begin
      int fd;
      int code;
      int idleCount;
      string op;
      string lineBuf;
      logic [`TRIG_ADDR_BITS-1:0] addr;
      logic [31:0] data;
      logic [31:0] expected;
      logic [31:0] got;
      logic [3:0] strb;
      frontLanesT frontVal;
      backLanesT backVal;

      proc_clk = 1'b0;
      reset = 1'b1;
      bus = '0;
      frontA = '0;
      trigAll = '0;
      lineCount = 0;
      lastRead = '0;
      testName = "reset";
      void'($urandom(32'hec511431));

      // first pass only counts lines
      fd = $fopen("verification/trig_tests.txt", "r");
      if (fd == 0)
      begin
         $display("could not open verification/trig_tests.txt");
         $display("*** TEST FAILED ***");
         $fatal(1, "no test data");
      end
      while ($fgets(lineBuf, fd) != 0)
      begin
         lineCount++;
      end
      $fclose(fd);
      if (lineCount == 0)
      begin
         $display("the test data file is empty");
         $display("*** TEST FAILED ***");
         $fatal(1, "no test data");
      end

      repeat (RESET_CYCLES) @(posedge proc_clk);
      #DRIVE_SKEW;
      reset = 1'b0;

      fd = $fopen("verification/trig_tests.txt", "r");
      while ($fscanf(fd, " %s", op) == 1)
      begin
         if (op == "#")
         begin
            // drop the rest of a comment line
            code = $fgets(lineBuf, fd);
         end
         else if (op == "T")
         begin
            code = $fscanf(fd, " %s", testName);
            if (code != 1)
               badLine(op);
            else
               $display("running %s", testName);
         end
         else if (op == "W")
         begin
            code = $fscanf(fd, " %h %h %h", addr, data, strb);
            if (code != 3)
               badLine(op);
            else
               writeWord(addr, data, strb);
         end
         else if (op == "I")
         begin
            code = $fscanf(fd, " %h %h", frontVal, backVal);
            if (code != 2)
               badLine(op);
            else
            begin
               frontA = frontVal;
               trigAll = backVal;
               nextCycle();
            end
         end
         else if (op == "D")
         begin
            code = $fscanf(fd, " %d", idleCount);
            if (code != 1)
               badLine(op);
            else
               repeat (idleCount) nextCycle();
         end
         else if (op == "R")
         begin
            code = $fscanf(fd, " %h %h", addr, expected);
            if (code != 2)
               badLine(op);
            else
            begin
               readWord(addr, got);
               checkValue($sformatf("read at %h", addr), expected, got);
               lastRead = got;
            end
         end
         else if (op == "K")
         begin
            // expected column is the step from the previous read
            code = $fscanf(fd, " %h %h", addr, expected);
            if (code != 2)
               badLine(op);
            else
            begin
               readWord(addr, got);
               checkValue($sformatf("step at %h", addr), expected, got - lastRead);
               lastRead = got;
            end
         end
         else
         begin
            badLine(op);
         end
      end
      $fclose(fd);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: design/trigTop.sv
`timescale 1ns/1ps

module trigTop
   import trigLogicPkg::*;
(
   input  logic        reset,
   input  logic        proc_clk,
   input  regBusT      bus,
   input  frontLanesT  frontA,
   input  backLanesT   trigAll,
   output logic [31:0] rdData
);

   frontCfgT frontCfg;
   backCfgT backCfg;
   matchResultT frontResult;
   matchResultT backResult;
   countsT counts;
   logic counterClear;

   // ************************************************************************
   // host registers and status readback
   // ************************************************************************
   regBank regs (
      .reset        (reset),
      .proc_clk     (proc_clk),
      .bus          (bus),
      .frontMatch   (frontResult),
      .backMatch    (backResult),
      .counts       (counts),
      .rdData       (rdData),
      .frontCfg     (frontCfg),
      .backCfg      (backCfg),
      .counterClear (counterClear),
      // run enable is only read back and gates nothing
      .runEnable    ()
   );

   // front panel group A
   groupMatch #(.laneT(frontLanesT)) frontMatch (
      .reset     (reset),
      .proc_clk  (proc_clk),
      .lanes     (frontA),
      .coincMask (frontCfg.coincMask),
      .multMask  (frontCfg.multMask),
      .pattern   (frontCfg.pattern),
      .threshold (frontCfg.threshold),
      .result    (frontResult)
   );

   // backplane group
   groupMatch #(.laneT(backLanesT)) backMatch (
      .reset     (reset),
      .proc_clk  (proc_clk),
      .lanes     (trigAll),
      .coincMask (backCfg.coincMask),
      .multMask  (backCfg.multMask),
      .pattern   (backCfg.pattern),
      .threshold (backCfg.threshold),
      .result    (backResult)
   );

   // counts triggers on backplane line 7
   runCounters counters (
      .reset        (reset),
      .proc_clk     (proc_clk),
      .trigLine     (trigAll[7]),
      .counterClear (counterClear),
      .counts       (counts)
   );

endmodule

// File: design/runCounters.sv
`timescale 1ns/1ps

module runCounters
   import trigLogicPkg::*;
(
   input  logic   reset,
   input  logic   proc_clk,
   input  logic   trigLine,
   input  logic   counterClear,
   output countsT counts
);

   logic trigA;
   logic trigB;
   logic trigRise;
   logic [63:0] numTrig;
   logic [63:0] runTicks;

   // ************************************************************************
   // edge detect on backplane line 7
   // ************************************************************************
   always_ff @(posedge proc_clk)
   begin
      if (reset)
      begin
         trigA <= 1'b0;
         trigB <= 1'b0;
      end
      else
      begin
         trigA <= trigLine;
         trigB <= trigA;
      end
   end

   // high for one cycle on the first registered high
   assign trigRise = trigA & ~trigB;

   // ************************************************************************
   // clear wins over counting
   // ************************************************************************
   always_ff @(posedge proc_clk)
   begin
      if (reset || counterClear)
      begin
         runTicks <= '0;
         numTrig <= '0;
      end
      else
      begin
         // one tick per proc_clk
         runTicks <= runTicks + 64'd1;
         if (trigRise)
         begin
            numTrig <= numTrig + 64'd1;
         end
      end
   end

   assign counts.numTrig = numTrig;
   assign counts.runTicks = runTicks;

   // at most one trigger per cycle
   trigStep: assert property (@(posedge proc_clk) disable iff (reset)
      !counterClear |=> (numTrig == $past(numTrig)) || (numTrig == $past(numTrig) + 64'd1));

endmodule

// File: design/groupMatch.sv
`timescale 1ns/1ps

module groupMatch
   import trigLogicPkg::*;
#(
   parameter type laneT = frontLanesT
)
(
   input  logic        reset,
   input  logic        proc_clk,
   input  laneT        lanes,
   input  laneT        coincMask,
   input  laneT        multMask,
   input  laneT        pattern,
   input  logic [7:0]  threshold,
   output matchResultT result
);

   // lane count comes from the payload type
   localparam int LANES = $bits(laneT);
   localparam int QUART = LANES / 4;
   localparam int PART_W = $clog2(QUART + 1);

   laneT multBits;
   logic [PART_W-1:0] partNext [4];
   logic [PART_W-1:0] partSum [4];
   logic [7:0] sum;

   // ************************************************************************
   // purely combinational coincidence
   // ************************************************************************
   assign result.coinc = ((lanes & coincMask) == pattern);

   // lanes that take part in the multiplicity
   assign multBits = lanes & multMask;

   // stage one input is a popcount per quarter
   always_comb
   begin
      for (int q = 0; q < 4; q++)
      begin
         partNext[q] = '0;
         for (int b = 0; b < QUART; b++)
         begin
            partNext[q] = partNext[q] + PART_W'(multBits[q*QUART + b]);
         end
      end
   end

   // ************************************************************************
   // two stage sum pipeline
   // ************************************************************************
   always_ff @(posedge proc_clk)
   begin
      if (reset)
      begin
         for (int q = 0; q < 4; q++)
         begin
            partSum[q] <= '0;
         end
         sum <= '0;
      end
      else
      begin
         partSum <= partNext;
         // second stage adds the quarters
         sum <= 8'(partSum[0]) + 8'(partSum[1]) + 8'(partSum[2]) + 8'(partSum[3]);
      end
   end

   assign result.sum = sum;
   // threshold compare on the registered sum
   assign result.mult = (sum >= threshold);

   // quarters can never add past the lane count
   sumInRange: assert property (@(posedge proc_clk) disable iff (reset)
      sum <= 8'(LANES));

endmodule

// File: design/regBank.sv
`timescale 1ns/1ps
`include "trigLogic_defines.svh"

module regBank
   import trigLogicPkg::*;
(
   input  logic        reset,
   input  logic        proc_clk,
   input  regBusT      bus,
   input  matchResultT frontMatch,
   input  matchResultT backMatch,
   input  countsT      counts,
   output logic [31:0] rdData,
   output frontCfgT    frontCfg,
   output backCfgT     backCfg,
   output logic        counterClear,
   output logic        runEnable
);

   localparam int DEPTH = 1 << `TRIG_ADDR_BITS;

   // one byte array per strobe lane
   logic [7:0] byteLane [4][DEPTH];

   logic [31:0] csrWord;
   logic [31:0] blockWord;
   logic [31:0] coincMaskA;
   logic [31:0] coincMaskB;
   logic [31:0] multMaskA;
   logic [31:0] multMaskB;
   logic [31:0] patternA;
   logic [31:0] patternB;
   logic [31:0] thresholdA;
   logic [31:0] thresholdB;
   logic [31:0] storedWord;
   logic [31:0] statusWord;
   logic [1:0] blockSel;

   // gather the four lanes of one word
   function automatic logic [31:0] storedAt(input logic [`TRIG_ADDR_BITS-1:0] a);
      storedAt = {byteLane[3][a], byteLane[2][a], byteLane[1][a], byteLane[0][a]};
   endfunction

   // ************************************************************************
   // write side where each strobe bit owns its byte
   // ************************************************************************
   always_ff @(posedge proc_clk)
   begin
      if (reset)
      begin
         for (int l = 0; l < 4; l++)
         begin
            for (int w = 0; w < DEPTH; w++)
            begin
               byteLane[l][w] <= '0;
            end
         end
      end
      else
      begin
         for (int l = 0; l < 4; l++)
         begin
            if (bus.wrStrb[l])
            begin
               byteLane[l][bus.addr] <= bus.wrData[l*8 +: 8];
            end
         end
      end
   end

   // configuration decode straight from the array
   always_comb
   begin
      csrWord = storedAt(`TRIG_ADDR_CSR);
      blockWord = storedAt(`TRIG_ADDR_OUTBLOCK);
      coincMaskA = storedAt(`TRIG_ADDR_COINC_MASK_A);
      coincMaskB = storedAt(`TRIG_ADDR_COINC_MASK_B);
      multMaskA = storedAt(`TRIG_ADDR_MULT_MASK_A);
      multMaskB = storedAt(`TRIG_ADDR_MULT_MASK_B);
      patternA = storedAt(`TRIG_ADDR_PATTERN_A);
      patternB = storedAt(`TRIG_ADDR_PATTERN_B);
      thresholdA = storedAt(`TRIG_ADDR_THRESHOLD_A);
      thresholdB = storedAt(`TRIG_ADDR_THRESHOLD_B);
      // word under the current address for block 0
      storedWord = storedAt(bus.addr);
   end

   // run enable is only reported and counting ignores it
   assign runEnable = csrWord[0];
   assign blockSel = blockWord[1:0];

   // front group uses the low half of its words
   assign frontCfg.coincMask = coincMaskA[`TRIG_FRONT_LANES-1:0];
   assign frontCfg.multMask = multMaskA[`TRIG_FRONT_LANES-1:0];
   assign frontCfg.pattern = patternA[`TRIG_FRONT_LANES-1:0];
   assign frontCfg.threshold = thresholdA[7:0];

   assign backCfg.coincMask = coincMaskB;
   assign backCfg.multMask = multMaskB;
   assign backCfg.pattern = patternB;
   assign backCfg.threshold = thresholdB[7:0];

   // ************************************************************************
   // status block map
   // ************************************************************************
   always_comb
   begin
      case (bus.addr)
         `TRIG_ADDR_CSR:          statusWord = {31'd0, runEnable};
         `TRIG_ADDR_VERSION:      statusWord = `TRIG_SYS_REVISION;
         // coinc flags in the low byte and mult flags in the next
         `TRIG_ADDR_COINC_RESULT: statusWord = {22'd0, backMatch.mult, frontMatch.mult,
                                                6'd0, backMatch.coinc, frontMatch.coinc};
         `TRIG_ADDR_NUMTRIG_LO:   statusWord = counts.numTrig[31:0];
         `TRIG_ADDR_NUMTRIG_HI:   statusWord = counts.numTrig[63:32];
         `TRIG_ADDR_RUNTICKS_LO:  statusWord = counts.runTicks[31:0];
         `TRIG_ADDR_RUNTICKS_HI:  statusWord = counts.runTicks[63:32];
         `TRIG_ADDR_SUM_A:        statusWord = {24'd0, frontMatch.sum};
         `TRIG_ADDR_SUM_B:        statusWord = {24'd0, backMatch.sum};
         default:                 statusWord = '0;
      endcase
   end

   // registered readback holds while rdEn is low
   always_ff @(posedge proc_clk)
   begin
      if (reset)
      begin
         rdData <= '0;
         counterClear <= 1'b0;
      end
      else
      begin
         if (bus.rdEn)
         begin
            case (blockSel)
               2'd0:    rdData <= storedWord;
               2'd1:    rdData <= statusWord;
               default: rdData <= `TRIG_BAD_BLOCK;
            endcase
         end
         // clear pulse follows the write by one cycle
         counterClear <= (|bus.wrStrb) && (bus.addr == `TRIG_ADDR_CLEAR);
      end
   end

   // a live request must carry a clean address
   addrKnown: assert property (@(posedge proc_clk) disable iff (reset)
      (bus.rdEn || (|bus.wrStrb)) |-> !$isunknown(bus.addr));

endmodule

// File: common/trigLogicPkg.sv
`include "trigLogic_defines.svh"

package trigLogicPkg;

   // ************************************************************************
   // lane vectors of the two groups
   // ************************************************************************
   typedef logic [`TRIG_FRONT_LANES-1:0] frontLanesT;
   typedef logic [`TRIG_BACK_LANES-1:0] backLanesT;

   // host request sampled on every proc_clk edge
   typedef struct packed {
      logic [3:0] wrStrb;
      logic rdEn;
      logic [`TRIG_ADDR_BITS-1:0] addr;
      logic [31:0] wrData;
   } regBusT;

   // ************************************************************************
   // per group configuration
   // ************************************************************************
   typedef struct packed {
      frontLanesT coincMask;
      frontLanesT multMask;
      frontLanesT pattern;
      logic [7:0] threshold;
   } frontCfgT;

   typedef struct packed {
      backLanesT coincMask;
      backLanesT multMask;
      backLanesT pattern;
      logic [7:0] threshold;
   } backCfgT;

   // coincidence flag, multiplicity flag, registered sum
   typedef struct packed {
      logic coinc;
      logic mult;
      logic [7:0] sum;
   } matchResultT;

   // free running counters
   typedef struct packed {
      logic [63:0] numTrig;
      logic [63:0] runTicks;
   } countsT;

endpackage

// File: common/trigLogic_defines.svh
`ifndef TRIG_LOGIC_DEFINES_SVH
`define TRIG_LOGIC_DEFINES_SVH

// ***************************************************************************
// trigger board register map and sizes
// ***************************************************************************

// lane counts of the kept input groups
`define TRIG_FRONT_LANES 16
`define TRIG_BACK_LANES 32

// word address width for 512 words
`define TRIG_ADDR_BITS 9

// product id in the upper half with variant and build numbers below
`define TRIG_SYS_REVISION 32'hB100_0001
// readback for block select 2 or 3
`define TRIG_BAD_BLOCK 32'h0000_0123

// write side control words
`define TRIG_ADDR_CSR 9'h000
`define TRIG_ADDR_OUTBLOCK 9'h003
`define TRIG_ADDR_CLEAR 9'h009

// group configuration where A is front panel and B is backplane
`define TRIG_ADDR_COINC_MASK_A 9'h108
`define TRIG_ADDR_COINC_MASK_B 9'h10B
`define TRIG_ADDR_MULT_MASK_A 9'h110
`define TRIG_ADDR_MULT_MASK_B 9'h113
`define TRIG_ADDR_PATTERN_A 9'h118
`define TRIG_ADDR_PATTERN_B 9'h11B
`define TRIG_ADDR_THRESHOLD_A 9'h120
`define TRIG_ADDR_THRESHOLD_B 9'h123

// status block read with block select 1
`define TRIG_ADDR_VERSION 9'h001
`define TRIG_ADDR_COINC_RESULT 9'h005
`define TRIG_ADDR_NUMTRIG_LO 9'h00A
`define TRIG_ADDR_NUMTRIG_HI 9'h00B
`define TRIG_ADDR_RUNTICKS_LO 9'h00C
`define TRIG_ADDR_RUNTICKS_HI 9'h00D
// sums share the mult mask addresses
`define TRIG_ADDR_SUM_A 9'h110
`define TRIG_ADDR_SUM_B 9'h113

`endif
